//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := lsu_tb
FILELIST  := tb.f

SRCS := $(shell grep -v '^+' $(FILELIST))
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN)
	@out="$$(./$(BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Simulation finished: PASS"

clean:
	rm -rf obj_dir

//--- rtl/lsu_bus_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_bus_ctrl (
  input  wire               clk,
  input  wire               arst_n_i,
  input  wire               pending_i,
  input  lsu_pkg::lsu_req_t held_req_i,
  input  wire               rsp_i,
  output logic              bus_valid_o,
  output lsu_pkg::bus_req_t bus_req_o
);

  logic [lsu_pkg::LFSR_W-1:0] lfsr_q;
  logic                       outstanding_q;
  logic                       gate_open;
  logic                       issue;
  logic [1:0]                 offset;
  logic [2:0]                 size;
  logic [3:0]                 strb_base;

  assign gate_open = !lsu_pkg::STALL_ENABLE || lfsr_q[lsu_pkg::LFSR_W-1];
  assign issue     = pending_i && !outstanding_q && gate_open;

  // While a request waits the LFSR runs only until its top bit opens the gate
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      lfsr_q <= lsu_pkg::LFSR_W'(1);
    end else if (!pending_i || !lfsr_q[lsu_pkg::LFSR_W-1]) begin
      lfsr_q <= {lfsr_q[lsu_pkg::LFSR_W-2:0],
                 lfsr_q[lsu_pkg::LFSR_W-1] ^ lfsr_q[lsu_pkg::LFSR_W-2]};
    end
  end

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      outstanding_q <= 1'b0;
    end else if (issue) begin
      outstanding_q <= 1'b1;
    end else if (rsp_i) begin
      outstanding_q <= 1'b0;
    end
  end

  assign offset = held_req_i.addr[1:0];
  assign size   = lsu_pkg::access_size(held_req_i.op);

  always_comb begin
    case (size)
      3'd1:    strb_base = 4'b0001;
      3'd2:    strb_base = 4'b0011;
      default: strb_base = 4'b1111;
    endcase
  end

  always_comb begin
    bus_req_o.idx   = held_req_i.addr[lsu_pkg::IDX_W+1:2];  // Wraps modulo the depth
    bus_req_o.we    = lsu_pkg::is_store(held_req_i.op);
    bus_req_o.strb  = bus_req_o.we ? (strb_base << offset) : 4'b0000;
    bus_req_o.wdata = held_req_i.wdata << {offset, 3'b000};
  end

  assign bus_valid_o = issue;

endmodule

`default_nettype wire

//--- rtl/lsu_dmem.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_dmem (
  input  wire                        clk,
  input  wire                        arst_n_i,
  input  wire                        bus_valid_i,
  input  lsu_pkg::bus_req_t          bus_req_i,
  output logic                       rvalid_o,
  output logic [lsu_pkg::DATA_W-1:0] rdata_o,
  output logic                       wready_o
);

  logic [lsu_pkg::DATA_W-1:0] mem [lsu_pkg::DMEM_WORDS];
  logic [lsu_pkg::DATA_W-1:0] rdata_q;
  logic                       rvalid_q;
  logic                       wready_q;

  // Byte-strobed write port and registered read
  always_ff @(posedge clk) begin
    if (bus_valid_i) begin
      if (bus_req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (bus_req_i.strb[b]) begin
            mem[bus_req_i.idx][8*b +: 8] <= bus_req_i.wdata[8*b +: 8];
          end
        end
      end else begin
        rdata_q <= mem[bus_req_i.idx];
      end
    end
  end

  // One response pulse per access, one cycle later
  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rvalid_q <= 1'b0;
      wready_q <= 1'b0;
    end else begin
      rvalid_q <= bus_valid_i && !bus_req_i.we;
      wready_q <= bus_valid_i && bus_req_i.we;
    end
  end

  assign rvalid_o = rvalid_q;
  assign rdata_o  = rdata_q;
  assign wready_o = wready_q;

endmodule

`default_nettype wire

//--- rtl/lsu_load_align.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_load_align (
  input  lsu_pkg::lsu_req_t          held_req_i,
  input  wire                        rvalid_i,
  input  wire [lsu_pkg::DATA_W-1:0]  rdata_i,
  output logic                       rvalid_o,
  output logic [lsu_pkg::DATA_W-1:0] rdata_o
);

  logic [lsu_pkg::DATA_W-1:0] shifted;
  logic                       signed_ld;
  logic [2:0]                 size;

  assign shifted   = rdata_i >> {held_req_i.addr[1:0], 3'b000};
  assign signed_ld = (held_req_i.op == lsu_pkg::LB) || (held_req_i.op == lsu_pkg::LH);
  assign size      = lsu_pkg::access_size(held_req_i.op);

  always_comb begin
    case (size)
      3'd1: begin
        rdata_o = {{(lsu_pkg::DATA_W-8){signed_ld && shifted[7]}}, shifted[7:0]};
      end
      3'd2: begin
        rdata_o = {{(lsu_pkg::DATA_W-16){signed_ld && shifted[15]}}, shifted[15:0]};
      end
      default: begin
        rdata_o = shifted;
      end
    endcase
  end

  assign rvalid_o = rvalid_i;

endmodule

`default_nettype wire

//--- rtl/lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  localparam int ADDR_W       = 32;
  localparam int DATA_W       = 32;
  localparam int DMEM_WORDS   = 64;
  localparam int IDX_W        = $clog2(DMEM_WORDS);
  localparam bit STALL_ENABLE = 1'b1;  // Random bus delay on issue
  localparam int LFSR_W       = 20;

  typedef enum logic [3:0] {
    LB,
    LBU,
    LH,
    LHU,
    LW,
    SB,
    SH,
    SW
  } lsu_op_e;

  typedef struct packed {
    lsu_op_e             op;
    logic [ADDR_W-1:0]   addr;
    logic [DATA_W-1:0]   wdata;
  } lsu_req_t;

  typedef struct packed {
    logic [IDX_W-1:0]    idx;
    logic                we;
    logic [3:0]          strb;
    logic [DATA_W-1:0]   wdata;  // Already placed on its byte lanes
  } bus_req_t;

  function automatic logic is_store(input lsu_op_e op);
    return (op == SB) || (op == SH) || (op == SW);
  endfunction

  // Access size in bytes
  function automatic logic [2:0] access_size(input lsu_op_e op);
    case (op)
      LB, LBU, SB: return 3'd1;
      LH, LHU, SH: return 3'd2;
      default:     return 3'd4;
    endcase
  endfunction

endpackage

`default_nettype wire

//--- rtl/lsu_req_latch.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_req_latch (
  input  wire               clk,
  input  wire               arst_n_i,
  input  wire               req_valid_i,
  input  lsu_pkg::lsu_req_t req_i,
  input  wire               done_i,
  output lsu_pkg::lsu_req_t held_req_o,
  output logic              pending_o,
  output logic              ready_o
);

  logic              accept;
  logic              pending_q;
  lsu_pkg::lsu_req_t held_q;

  assign accept = req_valid_i && !pending_q;  // Strobes while busy are dropped

  always_ff @(posedge clk or negedge arst_n_i) begin
    if (!arst_n_i) begin
      pending_q <= 1'b0;
    end else if (accept) begin
      pending_q <= 1'b1;
    end else if (done_i) begin
      pending_q <= 1'b0;
    end
  end

  // The held request stays put after completion so the load side can still see it
  always_ff @(posedge clk) begin
    if (accept) begin
      held_q <= req_i;
    end
  end

  assign held_req_o = held_q;
  assign pending_o  = pending_q;
  assign ready_o    = !pending_q;

endmodule

`default_nettype wire

//--- rtl/lsu_top.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_top (
  input  wire                        clk,
  input  wire                        arst_n_i,
  input  wire                        req_valid_i,
  input  lsu_pkg::lsu_req_t          req_i,
  output logic                       ready_o,
  output logic                       rvalid_o,
  output logic [lsu_pkg::DATA_W-1:0] rdata_o,
  output logic                       wready_o
);

  lsu_pkg::lsu_req_t          held_req;
  lsu_pkg::bus_req_t          bus_req;
  logic                       pending;
  logic                       bus_valid;
  logic                       rsp_rvalid;
  logic [lsu_pkg::DATA_W-1:0] rsp_rdata;
  logic                       rsp_wready;
  logic                       done;

  assign done     = rsp_rvalid || rsp_wready;  // Either response ends the request
  assign wready_o = rsp_wready;

  lsu_req_latch u_req_latch (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .done_i      (done),
    .held_req_o  (held_req),
    .pending_o   (pending),
    .ready_o     (ready_o)
  );

  lsu_bus_ctrl u_bus_ctrl (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .pending_i   (pending),
    .held_req_i  (held_req),
    .rsp_i       (done),
    .bus_valid_o (bus_valid),
    .bus_req_o   (bus_req)
  );

  lsu_dmem u_dmem (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .bus_valid_i (bus_valid),
    .bus_req_i   (bus_req),
    .rvalid_o    (rsp_rvalid),
    .rdata_o     (rsp_rdata),
    .wready_o    (rsp_wready)
  );

  lsu_load_align u_load_align (
    .held_req_i  (held_req),
    .rvalid_i    (rsp_rvalid),
    .rdata_i     (rsp_rdata),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o)
  );

endmodule

`default_nettype wire

//--- tb.f
rtl/lsu_pkg.sv
rtl/lsu_req_latch.sv
rtl/lsu_bus_ctrl.sv
rtl/lsu_dmem.sv
rtl/lsu_load_align.sv
rtl/lsu_top.sv
verif/lsu_tb.sv

//--- verif/lsu_tb.sv
`timescale 1ns/1ps
`default_nettype none

module lsu_tb;

  localparam int NUM_DIR   = 32;
  localparam int NUM_RAND  = 200;
  localparam int NUM_REQ   = NUM_DIR + NUM_RAND;
  localparam int MAX_STALL = 64;
  localparam int LIMIT     = NUM_REQ * (MAX_STALL + 4) + 100;  // Cycles before giving up

  typedef struct packed {
    lsu_pkg::lsu_op_e op;
    logic [31:0]      addr;
    logic [31:0]      wdata;
    logic [31:0]      exp;
  } entry_t;

  logic              clk;
  logic              arst_n_i;
  logic              req_valid_i;
  lsu_pkg::lsu_req_t req_i;
  logic              ready_o;
  logic              rvalid_o;
  logic [31:0]       rdata_o;
  logic              wready_o;

  entry_t      tbl [NUM_DIR];
  logic [7:0]  ref_mem [256];
  logic        written [256];
  logic [31:0] lfsr_state;
  int          errors;
  int          cycles;
  int          rsp_count;
  int          req_count;

  lsu_top dut0 (
    .clk         (clk),
    .arst_n_i    (arst_n_i),
    .req_valid_i (req_valid_i),
    .req_i       (req_i),
    .ready_o     (ready_o),
    .rvalid_o    (rvalid_o),
    .rdata_o     (rdata_o),
    .wready_o    (wready_o)
  );

  always #10 clk = ~clk;

  always @(posedge clk) begin
    cycles++;
    if (cycles >= LIMIT) begin
      $display("Timeout after %0d cycles, a request never completed", cycles);
      $display("Simulation finished: FAIL");
      $finish;
    end
  end

  // Count every response pulse away from the clock edge
  always @(negedge clk) begin
    if (arst_n_i && (rvalid_o || wready_o)) begin
      rsp_count++;
    end
  end

  task automatic next_cycle();
    @(posedge clk);
    #2;
  endtask

  task automatic check_val(input string name, input logic [31:0] exp, input logic [31:0] act);
    assert (exp === act) else begin
      errors++;
      $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
    end
  endtask

  // Galois LFSR stepped once per bit taken
  function automatic logic [31:0] get_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h8020_0003) : (lfsr_state >> 1);
      v = {v[30:0], lfsr_state[0]};
    end
    return v;
  endfunction

  function automatic int size_of(input lsu_pkg::lsu_op_e op);
    case (op)
      lsu_pkg::LB, lsu_pkg::LBU, lsu_pkg::SB: return 1;
      lsu_pkg::LH, lsu_pkg::LHU, lsu_pkg::SH: return 2;
      default: return 4;
    endcase
  endfunction

  function automatic bit is_store_op(input lsu_pkg::lsu_op_e op);
    return (op == lsu_pkg::SB) || (op == lsu_pkg::SH) || (op == lsu_pkg::SW);
  endfunction

  function automatic logic [31:0] ref_load(input lsu_pkg::lsu_op_e op, input logic [7:0] a);
    logic [7:0]  b;
    logic [15:0] h;
    b = ref_mem[a];
    h = {ref_mem[a + 8'd1], ref_mem[a]};
    case (op)
      lsu_pkg::LB:  return {{24{b[7]}}, b};
      lsu_pkg::LBU: return {24'h0, b};
      lsu_pkg::LH:  return {{16{h[15]}}, h};
      lsu_pkg::LHU: return {16'h0, h};
      default:      return {ref_mem[a + 8'd3], ref_mem[a + 8'd2], h};
    endcase
  endfunction

  task automatic ref_store(input lsu_pkg::lsu_op_e op, input logic [7:0] a, input logic [31:0] d);
    for (int i = 0; i < size_of(op); i++) begin
      ref_mem[a + 8'(i)] = d[8*i +: 8];
      written[a + 8'(i)] = 1'b1;
    end
  endtask

  // One request from strobe to the return of ready with an optional strobe while busy
  task automatic do_req(input string name, input lsu_pkg::lsu_op_e op, input logic [31:0] addr,
                        input logic [31:0] wdata, input bit poke, output logic [31:0] rdata);
    bit is_st;
    is_st = is_store_op(op);
    while (!ready_o) next_cycle();
    req_valid_i = 1'b1;
    req_i       = '{op: op, addr: addr, wdata: wdata};
    req_count++;
    next_cycle();
    assert (!ready_o) else begin
      errors++;
      $display("%s: ready_o stayed high after the request was accepted", name);
    end
    if (poke) begin
      req_i = '{op: lsu_pkg::SW, addr: addr, wdata: ~wdata};  // Must be dropped
      next_cycle();
    end
    req_valid_i = 1'b0;
    while (!(rvalid_o || wready_o)) next_cycle();
    assert (rvalid_o != wready_o && wready_o == is_st) else begin
      errors++;
      $display("%s: wrong response kind, rvalid_o=%b wready_o=%b", name, rvalid_o, wready_o);
    end
    rdata = rdata_o;
    next_cycle();
    assert (ready_o && !rvalid_o && !wready_o) else begin
      errors++;
      $display("%s: ready_o did not return or the response pulse lasted too long", name);
    end
  endtask

  task automatic init_table();
    tbl[0]  = '{lsu_pkg::SW,  32'h00, 32'h8bad_f00d, 32'h0};
    tbl[1]  = '{lsu_pkg::SW,  32'h04, 32'h1122_3344, 32'h0};
    tbl[2]  = '{lsu_pkg::LW,  32'h00, 32'h0, 32'h8bad_f00d};
    tbl[3]  = '{lsu_pkg::LW,  32'h04, 32'h0, 32'h1122_3344};
    tbl[4]  = '{lsu_pkg::SB,  32'h01, 32'hdead_bea5, 32'h0};  // Word 0 becomes 8bada50d
    tbl[5]  = '{lsu_pkg::SB,  32'h06, 32'h0000_007e, 32'h0};  // Word 1 becomes 117e3344
    tbl[6]  = '{lsu_pkg::SH,  32'h02, 32'h5555_c3d2, 32'h0};  // Word 0 becomes c3d2a50d
    tbl[7]  = '{lsu_pkg::LW,  32'h00, 32'h0, 32'hc3d2_a50d};
    tbl[8]  = '{lsu_pkg::LW,  32'h04, 32'h0, 32'h117e_3344};
    tbl[9]  = '{lsu_pkg::LB,  32'h00, 32'h0, 32'h0000_000d};
    tbl[10] = '{lsu_pkg::LB,  32'h01, 32'h0, 32'hffff_ffa5};
    tbl[11] = '{lsu_pkg::LBU, 32'h01, 32'h0, 32'h0000_00a5};
    tbl[12] = '{lsu_pkg::LB,  32'h02, 32'h0, 32'hffff_ffd2};
    tbl[13] = '{lsu_pkg::LBU, 32'h03, 32'h0, 32'h0000_00c3};
    tbl[14] = '{lsu_pkg::LB,  32'h03, 32'h0, 32'hffff_ffc3};
    tbl[15] = '{lsu_pkg::LH,  32'h00, 32'h0, 32'hffff_a50d};
    tbl[16] = '{lsu_pkg::LHU, 32'h00, 32'h0, 32'h0000_a50d};
    tbl[17] = '{lsu_pkg::LH,  32'h02, 32'h0, 32'hffff_c3d2};
    tbl[18] = '{lsu_pkg::LHU, 32'h02, 32'h0, 32'h0000_c3d2};
    tbl[19] = '{lsu_pkg::SH,  32'h04, 32'hffff_8001, 32'h0};  // Word 1 becomes 117e8001
    tbl[20] = '{lsu_pkg::LH,  32'h04, 32'h0, 32'hffff_8001};
    tbl[21] = '{lsu_pkg::LBU, 32'h07, 32'h0, 32'h0000_0011};
    tbl[22] = '{lsu_pkg::SB,  32'h04, 32'h1234_56ff, 32'h0};  // Word 1 becomes 117e80ff
    tbl[23] = '{lsu_pkg::LW,  32'h04, 32'h0, 32'h117e_80ff};
    tbl[24] = '{lsu_pkg::LB,  32'h05, 32'h0, 32'hffff_ff80};
    tbl[25] = '{lsu_pkg::LB,  32'h06, 32'h0, 32'h0000_007e};
    tbl[26] = '{lsu_pkg::LH,  32'h06, 32'h0, 32'h0000_117e};
    tbl[27] = '{lsu_pkg::SB,  32'h03, 32'h0000_0055, 32'h0};
    tbl[28] = '{lsu_pkg::LW,  32'h00, 32'h0, 32'h55d2_a50d};
    tbl[29] = '{lsu_pkg::LBU, 32'h02, 32'h0, 32'h0000_00d2};
    tbl[30] = '{lsu_pkg::LB,  32'h04, 32'h0, 32'hffff_ffff};
    tbl[31] = '{lsu_pkg::LBU, 32'h04, 32'h0, 32'h0000_00ff};
  endtask

  initial begin
    logic [31:0]      rd;
    logic [31:0]      v;
    logic [31:0]      addr;
    logic [31:0]      data;
    lsu_pkg::lsu_op_e op;
    bit               ok;
    clk = 1'b0;
    arst_n_i = 1'b0;
    req_valid_i = 1'b0;
    req_i = '0;
    lfsr_state = 32'h7cf3_ba1e;
    errors = 0;
    cycles = 0;
    rsp_count = 0;
    req_count = 0;
    for (int i = 0; i < 256; i++) written[i] = 1'b0;
    init_table();
    repeat (4) @(posedge clk);
    #2;
    arst_n_i = 1'b1;
    next_cycle();
    assert (ready_o && !rvalid_o && !wready_o) else begin
      errors++;
      $display("Reset state wrong, ready_o=%b rvalid_o=%b wready_o=%b",
               ready_o, rvalid_o, wready_o);
    end
    for (int i = 0; i < NUM_DIR; i++) begin
      do_req($sformatf("table[%0d] %s", i, tbl[i].op.name()), tbl[i].op, tbl[i].addr,
             tbl[i].wdata, 1'b1, rd);
      if (!is_store_op(tbl[i].op)) begin
        check_val($sformatf("table[%0d] %s", i, tbl[i].op.name()), tbl[i].exp, rd);
      end else begin
        ref_store(tbl[i].op, tbl[i].addr[7:0], tbl[i].wdata);
      end
    end
    for (int n = 0; n < NUM_RAND; n++) begin
      v = get_bits(3);
      op = lsu_pkg::lsu_op_e'(v[2:0]);
      v = get_bits(6);
      addr = {24'h0, v[5:0], 2'b00};
      v = get_bits(2);
      if (size_of(op) == 1) addr[1:0] = v[1:0];
      else if (size_of(op) == 2) addr[1:0] = {v[1], 1'b0};
      data = get_bits(32);
      ok = 1'b1;
      for (int i = 0; i < size_of(op); i++) ok &= written[addr[7:0] + 8'(i)];
      // A load of bytes never written turns into a store of the same size
      if (!ok && !is_store_op(op)) begin
        case (size_of(op))
          1:       op = lsu_pkg::SB;
          2:       op = lsu_pkg::SH;
          default: op = lsu_pkg::SW;
        endcase
      end
      do_req($sformatf("rand[%0d] %s", n, op.name()), op, addr, data, n[0], rd);
      if (is_store_op(op)) begin
        ref_store(op, addr[7:0], data);
      end else begin
        check_val($sformatf("rand[%0d] %s @%h", n, op.name(), addr),
                  ref_load(op, addr[7:0]), rd);
      end
    end
    repeat (2) next_cycle();
    assert (rsp_count == req_count) else begin
      errors++;
      $display("Response count %0d does not match request count %0d", rsp_count, req_count);
    end
    $display("Requests %0d, errors %0d", req_count, errors);
    if (errors == 0) begin
      $display("Simulation finished: PASS");
    end else begin
      $display("Simulation finished: FAIL");
    end
    $finish;
  end

endmodule

`default_nettype wire
